/* riscvPkg.sv */
package riscvPkg;

  // Architectural constants of the RV32I core that the front end feeds.
  localparam int unsigned xlen = 32;

  localparam logic [xlen-1:0] resetVector = 32'h0000_0000;

  // Without compressed instructions every fetch is one word.
  localparam logic [xlen-1:0] instBytes = 32'd4;

  // Kind of control transfer reported by the resolving stage.
  // Only brCond can train a counter toward not-taken.
  typedef enum logic [1:0] {
    brCond = 2'b00,
    brJal  = 2'b01,
    brJalr = 2'b10
  } BranchKind;

endpackage

/* predictorPkg.sv */
package predictorPkg;

  // Two-bit saturating counter, ordered from not-taken to taken.
  // The upper bit alone tells the predicted direction.
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } CounterState;

  // Sizing defaults for the pattern history table and the BTB.
  // Both must be powers of two since they are indexed by PC bits.
  localparam int unsigned defaultPhtEntries = 64;

  localparam int unsigned defaultBtbEntries = 16;

endpackage

/* PredictLookupIF.sv */
`timescale 1ns/1ps

// Fetch PC out to both predictors, and their answers back in the same cycle.
interface PredictLookupIF;
  logic [riscvPkg::xlen-1:0] pc;
  logic predictTaken;
  logic hit;
  logic [riscvPkg::xlen-1:0] target;

  modport fetch(
    output pc,
    input predictTaken,
    input hit,
    input target
  );

  modport predictor(
    input pc,
    output predictTaken
  );

  modport btb(
    input pc,
    output hit,
    output target
  );
endinterface

/* BranchUpdateIF.sv */
`timescale 1ns/1ps

// Resolved branch outcome, one update per cycle that valid is high.
interface BranchUpdateIF;
  logic valid;
  logic [riscvPkg::xlen-1:0] pc;
  logic taken;
  logic [riscvPkg::xlen-1:0] target;
  riscvPkg::BranchKind kind;

  modport source(
    output valid,
    output pc,
    output taken,
    output target,
    output kind
  );

  modport predictor(input valid, input pc, input taken, input kind);

  modport btb(input valid, input pc, input taken, input target);
endinterface

/* BranchPredictor.sv */
`timescale 1ns/1ps

module BranchPredictor #(
  parameter int unsigned phtEntries = predictorPkg::defaultPhtEntries
) (
  input logic clk,
  input logic rstN,
  PredictLookupIF.predictor lookup,
  BranchUpdateIF.predictor update
);
  localparam int unsigned idxBits = $clog2(phtEntries);

  predictorPkg::CounterState counters [phtEntries];

  logic [idxBits-1:0] lookupIdx;
  logic [idxBits-1:0] updateIdx;
  logic stepUp;

  // Moves a counter one step and holds it at either end.
  function automatic predictorPkg::CounterState stepCounter(
    input predictorPkg::CounterState cur,
    input logic up
  );
    predictorPkg::CounterState stepped;
    stepped = cur;
    case (cur)
      predictorPkg::strongNotTaken:
        stepped = up ? predictorPkg::weakNotTaken : predictorPkg::strongNotTaken;
      predictorPkg::weakNotTaken:
        stepped = up ? predictorPkg::weakTaken : predictorPkg::strongNotTaken;
      predictorPkg::weakTaken:
        stepped = up ? predictorPkg::strongTaken : predictorPkg::weakNotTaken;
      predictorPkg::strongTaken:
        stepped = up ? predictorPkg::strongTaken : predictorPkg::weakTaken;
      default:
        stepped = predictorPkg::weakNotTaken;
    endcase
    return stepped;
  endfunction

  // The two byte-offset bits are always zero for word-aligned fetches.
  assign lookupIdx = lookup.pc[idxBits+1:2];
  assign updateIdx = update.pc[idxBits+1:2];

  assign lookup.predictTaken = (counters[lookupIdx] == predictorPkg::weakTaken) ||
                               (counters[lookupIdx] == predictorPkg::strongTaken);

  // Jumps always count as taken, only a conditional branch can fall through.
  assign stepUp = (update.kind != riscvPkg::brCond) || update.taken;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < phtEntries; i++) begin
        counters[i] <= predictorPkg::weakNotTaken;
      end
    end else if (update.valid) begin
      counters[updateIdx] <= stepCounter(counters[updateIdx], stepUp);
    end
  end
endmodule

/* BTB.sv */
`timescale 1ns/1ps

module BTB #(
  parameter int unsigned btbEntries = predictorPkg::defaultBtbEntries
) (
  input logic clk,
  input logic rstN,
  PredictLookupIF.btb lookup,
  BranchUpdateIF.btb update
);
  localparam int unsigned idxBits = $clog2(btbEntries);
  localparam int unsigned tagBits = riscvPkg::xlen - idxBits - 2;

  logic [btbEntries-1:0] valid;
  logic [tagBits-1:0] tags [btbEntries];
  logic [riscvPkg::xlen-1:0] targets [btbEntries];

  logic [idxBits-1:0] lookupIdx;
  logic [tagBits-1:0] lookupTag;
  logic [idxBits-1:0] updateIdx;
  logic [tagBits-1:0] updateTag;
  logic fill;

  // Index sits just above the byte offset and the tag takes the rest of the PC.
  assign lookupIdx = lookup.pc[idxBits+1:2];
  assign lookupTag = lookup.pc[riscvPkg::xlen-1:idxBits+2];
  assign updateIdx = update.pc[idxBits+1:2];
  assign updateTag = update.pc[riscvPkg::xlen-1:idxBits+2];

  assign lookup.hit = valid[lookupIdx] && (tags[lookupIdx] == lookupTag);
  assign lookup.target = targets[lookupIdx];

  // Only taken branches allocate, so a not-taken outcome keeps the old entry.
  assign fill = update.valid && update.taken;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid <= '0;
    end else if (fill) begin
      valid[updateIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tags[updateIdx] <= updateTag;
      targets[updateIdx] <= update.target;
    end
  end
endmodule

/* FetchStage.sv */
`timescale 1ns/1ps

module FetchStage (
  input logic clk,
  input logic rstN,
  input logic stall,
  input logic redirectValid,
  input logic [riscvPkg::xlen-1:0] redirectPc,
  PredictLookupIF.fetch lookup,
  output logic [riscvPkg::xlen-1:0] fetchPc,
  output logic fetchValid,
  output logic predictedTaken
);
  logic [riscvPkg::xlen-1:0] pc;
  logic [riscvPkg::xlen-1:0] nextPc;

  assign lookup.pc = pc;

  // A taken counter is useless without a target, so both must agree.
  assign predictedTaken = lookup.hit && lookup.predictTaken;

  // Redirect wins over stall, so a flush is never lost while fetch is held.
  always_comb begin
    if (redirectValid) begin
      nextPc = redirectPc;
    end else if (stall) begin
      nextPc = pc;
    end else if (predictedTaken) begin
      nextPc = lookup.target;
    end else begin
      nextPc = pc + riscvPkg::instBytes;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= riscvPkg::resetVector;
    end else begin
      pc <= nextPc;
    end
  end

  // The slot fetched right after a redirect is the flushed one.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fetchValid <= 1'b0;
    end else begin
      fetchValid <= !redirectValid;
    end
  end

  assign fetchPc = pc;
endmodule

/* FrontEnd.sv */
`timescale 1ns/1ps

module FrontEnd #(
  parameter int unsigned phtEntries = predictorPkg::defaultPhtEntries,
  parameter int unsigned btbEntries = predictorPkg::defaultBtbEntries
) (
  input logic clk,
  input logic rstN,
  input logic stall,
  input logic redirectValid,
  input logic [riscvPkg::xlen-1:0] redirectPc,
  input logic updateValid,
  input logic [riscvPkg::xlen-1:0] updatePc,
  input logic updateTaken,
  input logic [riscvPkg::xlen-1:0] updateTarget,
  input riscvPkg::BranchKind updateKind,
  output logic [riscvPkg::xlen-1:0] fetchPc,
  output logic fetchValid,
  output logic predictedTaken
);
  PredictLookupIF lookupIf();

  BranchUpdateIF updateIf();

  // The resolving stage lives outside, its outcome arrives on plain ports.
  assign updateIf.valid = updateValid;
  assign updateIf.pc = updatePc;
  assign updateIf.taken = updateTaken;
  assign updateIf.target = updateTarget;
  assign updateIf.kind = updateKind;

  BranchPredictor #(
    .phtEntries(phtEntries)
  ) branchPredictor (
    .clk(clk),
    .rstN(rstN),
    .lookup(lookupIf),
    .update(updateIf)
  );

  BTB #(
    .btbEntries(btbEntries)
  ) btb (
    .clk(clk),
    .rstN(rstN),
    .lookup(lookupIf),
    .update(updateIf)
  );

  FetchStage fetchStage (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .redirectValid(redirectValid),
    .redirectPc(redirectPc),
    .lookup(lookupIf),
    .fetchPc(fetchPc),
    .fetchValid(fetchValid),
    .predictedTaken(predictedTaken)
  );
endmodule

/* FrontEndTb.sv */
`timescale 1ns/1ps

module FrontEndTb;
  localparam int unsigned phtEntries = predictorPkg::defaultPhtEntries;
  localparam int unsigned btbEntries = predictorPkg::defaultBtbEntries;
  localparam int clkPeriod = 4;
  localparam int runCycles = 3000;
  localparam int timeoutNs = 2 * runCycles * clkPeriod;
  localparam int poolSize = 24;

  logic clk;
  logic rstN;
  logic stall;
  logic redirectValid;
  logic [riscvPkg::xlen-1:0] redirectPc;
  logic updateValid;
  logic [riscvPkg::xlen-1:0] updatePc;
  logic updateTaken;
  logic [riscvPkg::xlen-1:0] updateTarget;
  riscvPkg::BranchKind updateKind;
  logic [riscvPkg::xlen-1:0] fetchPc;
  logic fetchValid;
  logic predictedTaken;

  // Values applied at the next rising edge.
  logic nRstN;
  logic nStall;
  logic nRedirect;
  logic [riscvPkg::xlen-1:0] nRedirectPc;
  logic nUpdValid;
  logic [riscvPkg::xlen-1:0] nUpdPc;
  logic nUpdTaken;
  logic [riscvPkg::xlen-1:0] nUpdTarget;
  riscvPkg::BranchKind nUpdKind;

  // Reference model state.
  logic [riscvPkg::xlen-1:0] modelPc;
  logic modelValid;
  int counterModel [phtEntries];
  logic btbValidModel [btbEntries];
  logic [riscvPkg::xlen-1:0] btbTagModel [btbEntries];
  logic [riscvPkg::xlen-1:0] btbTargetModel [btbEntries];

  logic [riscvPkg::xlen-1:0] pool [poolSize];
  integer seed;
  logic [31:0] r;
  int cycleCount = 0;
  int checks = 0;
  int errors = 0;

  FrontEnd #(
    .phtEntries(phtEntries),
    .btbEntries(btbEntries)
  ) uut (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .redirectValid(redirectValid),
    .redirectPc(redirectPc),
    .updateValid(updateValid),
    .updatePc(updatePc),
    .updateTaken(updateTaken),
    .updateTarget(updateTarget),
    .updateKind(updateKind),
    .fetchPc(fetchPc),
    .fetchValid(fetchValid),
    .predictedTaken(predictedTaken)
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic int phtIndex(input logic [riscvPkg::xlen-1:0] pc);
    return (pc >> 2) % phtEntries;
  endfunction

  function automatic int btbIndex(input logic [riscvPkg::xlen-1:0] pc);
    return (pc >> 2) % btbEntries;
  endfunction

  function automatic logic [riscvPkg::xlen-1:0] btbTag(input logic [riscvPkg::xlen-1:0] pc);
    return pc >> (2 + $clog2(btbEntries));
  endfunction

  // Taken needs both a matching BTB entry and a counter in one of the taken states.
  function automatic logic modelPredict(input logic [riscvPkg::xlen-1:0] pc);
    int bi;
    bi = btbIndex(pc);
    return btbValidModel[bi] && (btbTagModel[bi] == btbTag(pc)) &&
           (counterModel[phtIndex(pc)] >= 2);
  endfunction

  task automatic resetModel();
    modelPc = riscvPkg::resetVector;
    modelValid = 1'b0;
    for (int i = 0; i < phtEntries; i++) begin
      counterModel[i] = 1;
    end
    for (int i = 0; i < btbEntries; i++) begin
      btbValidModel[i] = 1'b0;
    end
  endtask

  task automatic checkOutputs();
    checks++;
    if (fetchPc !== modelPc) begin
      errors++;
      $display("FAILED fetchPc expected %h actual %h cycle %0d", modelPc, fetchPc, cycleCount);
    end
    if (fetchValid !== modelValid) begin
      errors++;
      $display("FAILED fetchValid expected %h actual %h cycle %0d", modelValid, fetchValid,
               cycleCount);
    end
    if (predictedTaken !== modelPredict(modelPc)) begin
      errors++;
      $display("FAILED predictedTaken expected %h actual %h cycle %0d", modelPredict(modelPc),
               predictedTaken, cycleCount);
    end
  endtask

  // Steps the model over the edge with the inputs the DUT sampled, then drives the next set.
  task automatic runCycle();
    logic predicted;
    int pi;
    int bi;
    @(posedge clk);
    if (!rstN) begin
      resetModel();
    end else begin
      predicted = modelPredict(modelPc);
      if (redirectValid) begin
        modelPc = redirectPc;
      end else if (!stall) begin
        if (predicted) begin
          modelPc = btbTargetModel[btbIndex(modelPc)];
        end else begin
          modelPc = modelPc + 4;
        end
      end
      modelValid = !redirectValid;
      if (updateValid) begin
        pi = phtIndex(updatePc);
        bi = btbIndex(updatePc);
        if ((updateKind != riscvPkg::brCond) || updateTaken) begin
          if (counterModel[pi] < 3) begin
            counterModel[pi]++;
          end
        end else if (counterModel[pi] > 0) begin
          counterModel[pi]--;
        end
        if (updateTaken) begin
          btbValidModel[bi] = 1'b1;
          btbTagModel[bi] = btbTag(updatePc);
          btbTargetModel[bi] = updateTarget;
        end
      end
    end
    rstN <= nRstN;
    stall <= nStall;
    redirectValid <= nRedirect;
    redirectPc <= nRedirectPc;
    updateValid <= nUpdValid;
    updatePc <= nUpdPc;
    updateTaken <= nUpdTaken;
    updateTarget <= nUpdTarget;
    updateKind <= nUpdKind;
    #1;
    checkOutputs();
    cycleCount++;
  endtask

  task automatic setIdle();
    nStall = 1'b0;
    nRedirect = 1'b0;
    nRedirectPc = '0;
    nUpdValid = 1'b0;
    nUpdPc = '0;
    nUpdTaken = 1'b0;
    nUpdTarget = '0;
    nUpdKind = riscvPkg::brCond;
  endtask

  task automatic redirectTo(input logic [riscvPkg::xlen-1:0] pc);
    setIdle();
    nRedirect = 1'b1;
    nRedirectPc = pc;
    runCycle();
    setIdle();
  endtask

  task automatic sendUpdate(input logic [riscvPkg::xlen-1:0] pc, input logic taken,
                            input logic [riscvPkg::xlen-1:0] target);
    setIdle();
    nUpdValid = 1'b1;
    nUpdPc = pc;
    nUpdTaken = taken;
    nUpdTarget = target;
    runCycle();
    setIdle();
  endtask

  initial begin
    #(timeoutNs);
    $display("Run timed out after %0d ns before all cycles were done", timeoutNs);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seed = 68831;
    clk = 1'b0;
    rstN = 1'b0;
    stall = 1'b0;
    redirectValid = 1'b0;
    redirectPc = '0;
    updateValid = 1'b0;
    updatePc = '0;
    updateTaken = 1'b0;
    updateTarget = '0;
    updateKind = riscvPkg::brCond;
    resetModel();
    // Groups of eight words; pool entries eight apart share a counter and a BTB slot.
    for (int i = 0; i < poolSize; i++) begin
      pool[i] = 32'h1000 + (i % 8) * 4 + (i / 8) * 32'h100;
    end
    setIdle();
    nRstN = 1'b0;
    repeat (16) runCycle();
    nRstN = 1'b1;
    repeat (20) runCycle();
    nStall = 1'b1;
    repeat (4) runCycle();
    nRedirect = 1'b1;
    nRedirectPc = pool[3];
    runCycle();
    nRedirect = 1'b0;
    repeat (3) runCycle();
    setIdle();
    repeat (4) runCycle();
    sendUpdate(pool[0], 1'b1, pool[5]);
    sendUpdate(pool[0], 1'b1, pool[5]);
    redirectTo(pool[0]);
    repeat (3) runCycle();
    // Tag alias with a taken counter must still go sequential.
    redirectTo(pool[16]);
    repeat (3) runCycle();
    redirectTo(pool[0]);
    sendUpdate(pool[0], 1'b0, '0);
    sendUpdate(pool[0], 1'b0, '0);
    redirectTo(pool[0]);
    repeat (3) runCycle();
    // The taken update lands while pool[0] is fetched and its counter sits just below taken.
    redirectTo(pool[0]);
    sendUpdate(pool[0], 1'b1, pool[5]);
    repeat (3) runCycle();
    while (cycleCount < runCycles) begin
      r = $random(seed);
      nStall = (r[2:0] == 3'd0);
      nRedirect = (r[6:3] == 4'd0);
      nRedirectPc = pool[$unsigned($random(seed)) % poolSize];
      nUpdValid = r[7];
      nUpdPc = pool[$unsigned($random(seed)) % poolSize];
      nUpdTaken = r[8] | r[9];
      nUpdTarget = pool[$unsigned($random(seed)) % poolSize];
      nUpdKind = riscvPkg::BranchKind'($unsigned($random(seed)) % 3);
      runCycle();
    end
    $display("Ran %0d cycles, %0d checks, %0d errors", cycleCount, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end
endmodule

/* sim.f */
riscvPkg.sv
predictorPkg.sv
PredictLookupIF.sv
BranchUpdateIF.sv
BranchPredictor.sv
BTB.sv
FetchStage.sv
FrontEnd.sv
FrontEndTb.sv
